// File: hw/keypad_consts.svh
`ifndef KEYPAD_CONSTS_SVH
`define KEYPAD_CONSTS_SVH

// dwell per column in clocks.
`define KEYPAD_SCAN_CYCLES 250000

// events held before drop.
`define KEYPAD_FIFO_DEPTH 16

// register byte offsets.
`define KEYPAD_REG_STATUS 4'h0
`define KEYPAD_REG_DATA 4'h4
`define KEYPAD_REG_CTRL 4'h8

`endif

// File: hw/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

    // **************************************************************************
    // key events
    // **************************************************************************

    typedef enum logic {
        KEY_PRESS   = 1'b0,
        KEY_RELEASE = 1'b1
    } key_evt_kind_e;

    typedef struct packed {
        key_evt_kind_e kind;
        logic [3:0]    key_id;  // row * 4 + col.
    } key_event_t;

    // **************************************************************************
    // scanner and status
    // **************************************************************************

    typedef enum logic [1:0] {
        SCAN_DRIVE  = 2'd0,
        SCAN_SAMPLE = 2'd1
    } scan_state_e;

    typedef struct packed {
        logic [1:0] rsvd;
        logic       overflow;  // sticky until cleared.
        logic [4:0] count;
    } key_status_t;

endpackage

`default_nettype wire

// File: hw/keypad_scanner.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_consts.svh"

module keypad_scanner #(
    parameter int SCAN_CYCLES = `KEYPAD_SCAN_CYCLES
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [3:0]             row_in,
    output logic [3:0]             col_out,
    output keypad_pkg::key_event_t evt,
    output logic                   evt_valid
);

    localparam int CW = (SCAN_CYCLES > 2) ? $clog2(SCAN_CYCLES) : 1;
    localparam logic [CW-1:0] LAST_DRIVE = CW'(SCAN_CYCLES - 2);

    keypad_pkg::scan_state_e state;
    logic [CW-1:0] dwell_cnt;
    logic [1:0]    col_idx;
    logic [1:0]    next_col;
    logic [3:0]    row_smp;
    logic [15:0]   key_map;   // set while key is held.
    logic [3:0]    pressed;
    logic [3:0]    stored;
    logic [3:0]    changed;
    logic          chg_any;
    logic [1:0]    chg_row;
    logic          smp_now;

    assign next_col = col_idx + 2'd1;
    assign smp_now  = (state == keypad_pkg::SCAN_DRIVE) && (dwell_cnt == LAST_DRIVE);

    // **************************************************************************
    // change detection for the current column
    // **************************************************************************

    always_comb begin
        pressed = ~row_smp;  // rows are active low.
        for (int r = 0; r < 4; r++) begin
            stored[r] = key_map[{2'(r), col_idx}];
        end
        changed = pressed ^ stored;
        chg_any = |changed;
        chg_row = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (changed[r]) begin
                chg_row = 2'(r);  // lowest row wins.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= keypad_pkg::SCAN_DRIVE;
            dwell_cnt <= '0;
            col_idx   <= 2'd0;
            col_out   <= 4'b0111;
            key_map   <= '0;
            evt_valid <= 1'b0;
        end else begin
            evt_valid <= 1'b0;
            case (state)
                keypad_pkg::SCAN_DRIVE: begin
                    if (smp_now) begin
                        state <= keypad_pkg::SCAN_SAMPLE;
                    end else begin
                        dwell_cnt <= dwell_cnt + 1'b1;
                    end
                end
                keypad_pkg::SCAN_SAMPLE: begin
                    if (chg_any) begin
                        evt_valid                   <= 1'b1;
                        key_map[{chg_row, col_idx}] <= pressed[chg_row];
                    end
                    col_idx   <= next_col;
                    col_out   <= ~(4'b1000 >> next_col);  // col 0 on bit 3.
                    dwell_cnt <= '0;
                    state     <= keypad_pkg::SCAN_DRIVE;
                end
                default: state <= keypad_pkg::SCAN_DRIVE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (smp_now) begin
            row_smp <= row_in;
        end
        if (state == keypad_pkg::SCAN_SAMPLE) begin
            evt.kind   <= pressed[chg_row] ? keypad_pkg::KEY_PRESS : keypad_pkg::KEY_RELEASE;
            evt.key_id <= {chg_row, col_idx};
        end
    end

    a_one_col_low: assert property (@(posedge clk) disable iff (!rst_n)
        $countones(~col_out) == 1);

endmodule

`default_nettype wire

// File: hw/key_event_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_consts.svh"

module key_event_fifo #(
    parameter int DEPTH = `KEYPAD_FIFO_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  keypad_pkg::key_event_t din,
    input  logic                   pop,
    output keypad_pkg::key_event_t head,
    output logic [4:0]             count,
    output logic                   drop
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [AW-1:0] LAST_IDX = AW'(DEPTH - 1);
    localparam logic [4:0] FULL_CNT = 5'(DEPTH);

    keypad_pkg::key_event_t mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full    = (count == FULL_CNT);
    assign do_push = push && !full;
    assign do_pop  = pop && (count != 5'd0);
    assign head    = mem[rd_ptr];  // first word fall through.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 5'd0;
            drop   <= 1'b0;
        end else begin
            drop <= push && full;  // event lost.
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 5'd1;
                2'b01:   count <= count - 5'd1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= FULL_CNT);

endmodule

`default_nettype wire

// File: hw/axil_key_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_consts.svh"

module axil_key_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [3:0]             awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [3:0]             araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    input  keypad_pkg::key_event_t head,
    input  logic [4:0]             count,
    input  logic                   drop,
    output logic                   pop
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [3:0] ADDR_STATUS = `KEYPAD_REG_STATUS;
    localparam logic [3:0] ADDR_DATA   = `KEYPAD_REG_DATA;
    localparam logic [3:0] ADDR_CTRL   = `KEYPAD_REG_CTRL;

    keypad_pkg::key_status_t status;
    logic        overflow;
    logic        nonempty;
    logic [4:0]  head_bits;
    logic        wr_fire;
    logic        rd_fire;
    logic        wr_err;
    logic        rd_err;
    logic        ctrl_clr;
    logic [31:0] rd_word;

    assign nonempty  = (count != 5'd0);
    assign head_bits = nonempty ? head : 5'd0;  // empty reads 0.
    assign wr_fire   = awvalid && awready && wvalid && wready;
    assign rd_fire   = arvalid && arready;
    assign pop       = rd_fire && (araddr == ADDR_DATA) && nonempty;
    assign wr_err    = !(awaddr inside {ADDR_STATUS, ADDR_DATA, ADDR_CTRL});
    assign ctrl_clr  = wr_fire && (awaddr == ADDR_CTRL) && wdata[0];

    // **************************************************************************
    // read decode
    // **************************************************************************

    always_comb begin
        status          = '0;
        status.count    = count;
        status.overflow = overflow;
        rd_err          = 1'b0;
        case (araddr)
            ADDR_STATUS: rd_word = {23'd0, nonempty, status};
            ADDR_DATA:   rd_word = {26'd0, nonempty, head_bits};
            ADDR_CTRL:   rd_word = 32'd0;
            default: begin
                rd_word = 32'd0;
                rd_err  = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            overflow <= 1'b0;
        end else begin
            awready <= 1'b0;
            wready  <= 1'b0;
            if (awvalid && wvalid && !awready && !bvalid) begin
                awready <= 1'b1;  // one-cycle accept.
                wready  <= 1'b1;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            arready <= 1'b0;
            if (arvalid && !arready && !rvalid) begin
                arready <= 1'b1;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (ctrl_clr) begin
                overflow <= 1'b0;
            end
            if (drop) begin
                overflow <= 1'b1;  // a new drop beats the clear.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
        if (wr_fire) begin
            bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// File: hw/keypad_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_consts.svh"

module keypad_ctrl_top #(
    parameter int SCAN_CYCLES = `KEYPAD_SCAN_CYCLES,
    parameter int FIFO_DEPTH  = `KEYPAD_FIFO_DEPTH
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  row_in,
    output logic [3:0]  col_out,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    keypad_pkg::key_event_t evt;
    keypad_pkg::key_event_t head;
    logic                   evt_valid;
    logic [4:0]             count;
    logic                   drop;
    logic                   pop;

    keypad_scanner #(
        .SCAN_CYCLES (SCAN_CYCLES)
    ) u_scanner (
        .clk       (clk),
        .rst_n     (rst_n),
        .row_in    (row_in),
        .col_out   (col_out),
        .evt       (evt),
        .evt_valid (evt_valid)
    );

    key_event_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (evt_valid),
        .din   (evt),
        .pop   (pop),
        .head  (head),
        .count (count),
        .drop  (drop)
    );

    axil_key_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .head    (head),
        .count   (count),
        .drop    (drop),
        .pop     (pop)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;  // released on a rising edge.
    end

endmodule

`default_nettype wire

// File: tests/tb_keypad_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "keypad_consts.svh"

module tb_keypad_ctrl;

    localparam int SCAN_CYCLES   = 8;
    localparam int FIFO_DEPTH    = 4;
    localparam int PASS_CLKS     = 4 * SCAN_CYCLES;
    localparam int SETTLE_CLKS   = 2 * PASS_CLKS + 8;  // two passes plus pipeline slack.
    localparam int N_SINGLE      = 12;
    localparam int N_PAIRS       = 3;
    localparam int N_OVF         = FIFO_DEPTH + 2;
    localparam int N_SETTLES     = N_SINGLE + N_PAIRS + N_OVF + 3;
    localparam int WATCHDOG_CLKS = N_SETTLES * (SETTLE_CLKS + 100) + 500;
    localparam int HS_LIMIT      = 20;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic        clk;
    logic        rst_n;
    logic [3:0]  row_in;
    logic [3:0]  col_out;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    logic [15:0] pressed;      // keys held in the matrix model.
    logic [31:0] rng;
    logic [4:0]  exp_q[$];     // predicted FIFO contents.
    logic        exp_ovf;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    keypad_ctrl_top #(
        .SCAN_CYCLES (SCAN_CYCLES),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .row_in  (row_in),
        .col_out (col_out),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    // ************************************************************************
    // helpers
    // ************************************************************************

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // row reads low when a held key sits in the driven column.
    function automatic logic [3:0] rows_for(input logic [3:0] cols, input logic [15:0] keys);
        logic [3:0] rows;
        rows = 4'hf;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (!cols[3 - c] && keys[r * 4 + c]) begin
                    rows[r] = 1'b0;  // col 0 sits on bit 3.
                end
            end
        end
        return rows;
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_eq(input string what, input logic [31:0] got,
                            input logic [31:0] expected);
        if (got !== expected) begin
            stop_run($sformatf("** Error @ %0t ns: %s got 0x%08h, expected 0x%08h",
                               $time, what, got, expected));
        end
    endtask

    task automatic note_event(input logic kind, input logic [3:0] id);
        if (exp_q.size() < FIFO_DEPTH) begin
            exp_q.push_back({kind, id});
        end else begin
            exp_ovf = 1'b1;  // dropped by a full FIFO.
        end
    endtask

    // flips every key in mask; ascending id keeps lower rows first.
    task automatic toggle_keys(input logic [15:0] mask);
        logic kind;
        @(posedge clk);
        for (int k = 0; k < 16; k++) begin
            if (mask[k]) begin
                kind = pressed[k] ? 1'(keypad_pkg::KEY_RELEASE) : 1'(keypad_pkg::KEY_PRESS);
                note_event(kind, 4'(k));
            end
        end
        pressed <= pressed ^ mask;
    endtask

    task automatic settle();
        repeat (SETTLE_CLKS) @(posedge clk);
    endtask

    task automatic read_reg(input logic [3:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        int waited;
        waited = 0;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) begin
            waited++;
            if (waited > HS_LIMIT) begin
                stop_run("read address was never accepted by the slave");
            end
            @(negedge clk);
        end
        @(posedge clk);  // ar handshake.
        arvalid <= 1'b0;
        @(negedge clk);
        check_eq("rvalid one clock after ar", 32'(rvalid), 32'd1);
        data = rdata;
        resp = rresp;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_eq("rvalid held", 32'(rvalid), 32'd1);
            check_eq("rdata held", rdata, data);
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);  // r handshake.
        rready <= 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int waited;
        waited = 0;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!(awready && wready)) begin
            waited++;
            if (waited > HS_LIMIT) begin
                stop_run("write address and data were never accepted by the slave");
            end
            @(negedge clk);
        end
        @(posedge clk);  // aw/w handshake.
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        @(negedge clk);
        check_eq("bvalid one clock after aw/w", 32'(bvalid), 32'd1);
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic check_status();
        logic [31:0] data;
        logic [1:0]  resp;
        logic [31:0] expected;
        expected = {23'd0, exp_q.size() != 0, 2'b00, exp_ovf, 5'(exp_q.size())};
        read_reg(`KEYPAD_REG_STATUS, 0, data, resp);
        check_eq("STATUS resp", 32'(resp), 32'(OKAY));
        check_eq("STATUS", data, expected);
    endtask

    task automatic pop_events();
        logic [31:0] data;
        logic [1:0]  resp;
        while (exp_q.size() > 0) begin
            read_reg(`KEYPAD_REG_DATA, 0, data, resp);
            check_eq("DATA resp", 32'(resp), 32'(OKAY));
            check_eq("DATA event", data, {26'd0, 1'b1, exp_q.pop_front()});
        end
    endtask

    // ************************************************************************
    // matrix model, watchdog and test sequence
    // ************************************************************************

    initial begin
        row_in = 4'hf;
        forever begin
            @(posedge clk);
            row_in <= rows_for(col_out, pressed);
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CLKS) @(posedge clk);
        stop_run("watchdog expired before the test sequence finished");
    end

    initial begin : main
        logic [31:0] data;
        logic [1:0]  resp;
        int          hold;
        logic [1:0]  col;
        logic [1:0]  r0;
        logic [1:0]  r1;
        awaddr  = 4'd0;
        awvalid = 1'b0;
        wdata   = 32'd0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = 4'd0;
        arvalid = 1'b0;
        rready  = 1'b0;
        pressed = 16'd0;
        exp_ovf = 1'b0;
        rng     = 32'hc8b9_a0d3;
        wait (rst_n === 1'b1);
        @(posedge clk);

        // reset state.
        check_status();
        read_reg(`KEYPAD_REG_DATA, 0, data, resp);
        check_eq("empty DATA", data, 32'd0);

        for (int i = 0; i < N_SINGLE; i++) begin
            rng = xorshift32(rng);
            toggle_keys(16'd1 << rng[3:0]);
            settle();
            check_status();
            pop_events();
        end

        // two rows of one column in the same scan.
        for (int i = 0; i < N_PAIRS; i++) begin
            rng = xorshift32(rng);
            col = rng[1:0];
            r0  = rng[3:2];
            r1  = r0 + 2'd1 + 2'(rng[5:4] % 3);
            toggle_keys((16'd1 << {r0, col}) | (16'd1 << {r1, col}));
            settle();
            check_status();
            pop_events();
        end

        for (int i = 0; i < N_OVF; i++) begin
            rng = xorshift32(rng);
            toggle_keys(16'd1 << rng[3:0]);
            settle();
        end
        check_status();
        write_reg(`KEYPAD_REG_STATUS, 32'hffff_ffff, resp);
        check_eq("STATUS write resp", 32'(resp), 32'(OKAY));
        check_status();  // read-only, count and overflow kept.
        pop_events();
        check_status();  // overflow stays sticky.
        write_reg(`KEYPAD_REG_CTRL, 32'd1, resp);
        check_eq("CTRL write resp", 32'(resp), 32'(OKAY));
        exp_ovf = 1'b0;
        check_status();

        rng = xorshift32(rng);
        toggle_keys(16'd1 << rng[3:0]);
        settle();
        write_reg(4'hc, 32'd1, resp);
        check_eq("unmapped write resp", 32'(resp), 32'(SLVERR));
        read_reg(4'hc, 0, data, resp);
        check_eq("unmapped read resp", 32'(resp), 32'(SLVERR));
        check_eq("unmapped read data", data, 32'd0);
        check_status();
        pop_events();

        // stalled read pops exactly one event.
        for (int i = 0; i < 2; i++) begin
            rng = xorshift32(rng);
            toggle_keys(16'd1 << rng[3:0]);
            settle();
        end
        rng  = xorshift32(rng);
        hold = 1 + int'(rng % 6);
        read_reg(`KEYPAD_REG_DATA, hold, data, resp);
        check_eq("stalled DATA resp", 32'(resp), 32'(OKAY));
        check_eq("stalled DATA event", data, {26'd0, 1'b1, exp_q.pop_front()});
        check_status();
        pop_events();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: keypad_ctrl_top.f
+incdir+hw
hw/keypad_pkg.sv
hw/keypad_scanner.sv
hw/key_event_fifo.sv
hw/axil_key_regs.sv
hw/keypad_ctrl_top.sv
tests/tb_clock_gen.sv
tests/tb_keypad_ctrl.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_keypad_ctrl
FILELIST := keypad_ctrl_top.f
OBJ_DIR  := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
